// File: class_scorer/class_scorer.sv
`timescale 1ns/1ps

module class_scorer
    import bnn_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  hidden_half_t half_lo,
    input  hidden_half_t half_hi,
    output score_vec_t   scores
);

    logic [HIDDEN_CNT-1:0]                hidden;
    logic [HIDDEN_CNT-1:0]                agree [CLASS_CNT];
    logic [CLASS_CNT-1:0][SCORE_BITS-1:0] score_d;
    logic                                 score_ovf;

    assign hidden = {half_hi.bits, half_lo.bits};   // bank 0 in the low bits

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // xnor popcount per class
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        for (int c = 0; c < CLASS_CNT; c++) begin
            agree[c]   = ~(hidden ^ CLS_WEIGHTS[c]);
            score_d[c] = '0;
            for (int h = 0; h < HIDDEN_CNT; h++) begin
                score_d[c] = score_d[c] + SCORE_BITS'(agree[c][h]);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scores <= '0;
        end else begin
            scores.valid <= half_lo.valid;
            scores.score <= score_d;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        score_ovf = 1'b0;
        for (int c = 0; c < CLASS_CNT; c++) begin
            if (scores.score[c] > SCORE_BITS'(HIDDEN_CNT)) begin
                score_ovf = 1'b1;
            end
        end
    end

    // both banks see the same sample stream
    a_half_sync : assert property (
        @(posedge clk) disable iff (!arst_n)
        half_lo.valid == half_hi.valid
    ) else $error("hidden bank valids out of step");

    a_score_range : assert property (
        @(posedge clk) disable iff (!arst_n)
        scores.valid |-> !score_ovf
    ) else $error("class score above %0d", HIDDEN_CNT);

endmodule

// File: common/bnn_pkg.sv
package bnn_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int FEAT_CNT   = 16;
    localparam int FEAT_BITS  = 4;
    localparam int BANK_CNT   = 2;
    localparam int BANK_SIZE  = 8;
    localparam int HIDDEN_CNT = BANK_CNT * BANK_SIZE;   // 16 neurons
    localparam int CLASS_CNT  = 10;
    localparam int CLASS_BITS = 4;
    localparam int SUM_BITS   = 8;                      // signed neuron sum
    localparam int SCORE_BITS = 5;                      // 0 to 16

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage words
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic                                valid;
        logic [FEAT_CNT-1:0][FEAT_BITS-1:0]  feat;
    } sample_t;

    typedef struct packed {
        logic                  valid;
        logic [BANK_SIZE-1:0]  bits;
    } hidden_half_t;

    typedef struct packed {
        logic                                 valid;
        logic [CLASS_CNT-1:0][SCORE_BITS-1:0] score;
    } score_vec_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // hidden layer tables
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // weight codes per feature: 00 skip, 01 add, 11 subtract, 10 reserved
    // feature 0 sits in the low two bits of each row
    // at most 8 weights of either sign per row so any sum fits in SUM_BITS
    localparam logic [FEAT_CNT-1:0][1:0] HID_WEIGHTS [HIDDEN_CNT] = '{
        32'h5d0c_3714,  // neuron 0
        32'hc3f1_0d57,
        32'h1707_fc45,
        32'h0f51_c3d0,
        32'h4475_10cd,
        32'hf3c0_7cc1,
        32'h51d3_0f74,
        32'h3d05_dc71,  // neuron 7, end of bank 0
        32'h7070_5f13,  // neuron 8
        32'hcd41_3075,
        32'h1f0c_d534,
        32'h450f_7c01,
        32'hd7c3_1504,
        32'h03fd_4c75,
        32'h5541_0c3f,
        32'hc17d_30f5   // neuron 15
    };

    // roughly the mean sum for uniform features so bits split evenly
    localparam logic signed [SUM_BITS-1:0] HID_THRESH [HIDDEN_CNT] = '{
        15, -8, 7, -7, 30, -38, 8, 6,
        0, 14, -2, 9, 16, -6, 13, -9
    };

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output layer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bit h of a row is the expected hidden bit h for that class
    localparam logic [HIDDEN_CNT-1:0] CLS_WEIGHTS [CLASS_CNT] = '{
        16'hb4e1,   // class 0
        16'h3a5c,
        16'hc72d,
        16'h5f08,
        16'h91b6,
        16'h2ec3,
        16'he659,
        16'h48f7,
        16'ha31e,
        16'h7d94    // class 9
    };

endpackage

// File: compile.f
+incdir+testbench
common/bnn_pkg.sv
hidden_bank/hidden_bank.sv
class_scorer/class_scorer.sv
verilog/argmax.sv
verilog/bnn_classifier.sv
testbench/bnn_classifier_tb.sv

// File: hidden_bank/hidden_bank.sv
`timescale 1ns/1ps

module hidden_bank
    import bnn_pkg::*;
#(
    parameter int BANK = 0
) (
    input  logic         clk,
    input  logic         arst_n,
    input  sample_t      sample,
    output hidden_half_t half
);

    // first global neuron of this bank
    localparam int BASE = BANK * BANK_SIZE;

    logic signed [SUM_BITS-1:0] sum [BANK_SIZE];
    logic [BANK_SIZE-1:0]       fire;
    logic                       bad_code;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ternary neurons
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        for (int n = 0; n < BANK_SIZE; n++) begin
            sum[n] = '0;
            for (int f = 0; f < FEAT_CNT; f++) begin
                case (HID_WEIGHTS[BASE+n][f])
                    2'b01:   sum[n] = sum[n] + SUM_BITS'(sample.feat[f]);
                    2'b11:   sum[n] = sum[n] - SUM_BITS'(sample.feat[f]);
                    default: ;  // zero weight
                endcase
            end
            fire[n] = (sum[n] >= HID_THRESH[BASE+n]);   // signed compare
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            half <= '0;
        end else begin
            half.valid <= sample.valid;
            half.bits  <= fire;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // scan only the rows owned by this bank
    always_comb begin
        bad_code = 1'b0;
        for (int n = 0; n < BANK_SIZE; n++) begin
            for (int f = 0; f < FEAT_CNT; f++) begin
                if (HID_WEIGHTS[BASE+n][f] == 2'b10) begin
                    bad_code = 1'b1;
                end
            end
        end
    end

    a_weight_code : assert property (
        @(posedge clk) disable iff (!arst_n)
        sample.valid |-> !bad_code
    ) else $error("hidden_bank %0d uses reserved weight code 10", BANK);

endmodule

// File: run.sh
#!/bin/sh
# build and run the classifier testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module bnn_classifier_tb

sim_out=$(./obj_dir/Vbnn_classifier_tb)
echo "$sim_out"

if echo "$sim_out" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1

// File: testbench/bnn_model.svh
`ifndef BNN_MODEL_SVH
`define BNN_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// golden model built from the package tables
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// one bit per neuron, sum of ternary weight times unsigned feature
function automatic logic [HIDDEN_CNT-1:0] model_hidden(
    input logic [FEAT_CNT*FEAT_BITS-1:0] feats
);
    logic [HIDDEN_CNT-1:0] hid;
    int                    sum;
    int                    val;
    hid = '0;
    for (int n = 0; n < HIDDEN_CNT; n++) begin
        sum = 0;
        for (int f = 0; f < FEAT_CNT; f++) begin
            val = int'(feats[f*FEAT_BITS +: FEAT_BITS]);
            if (HID_WEIGHTS[n][f] == 2'b01) begin
                sum = sum + val;
            end else if (HID_WEIGHTS[n][f] == 2'b11) begin
                sum = sum - val;
            end
        end
        hid[n] = (sum >= int'(HID_THRESH[n]));
    end
    return hid;
endfunction

// agreement count between hidden bits and each class row
function automatic logic [CLASS_CNT-1:0][SCORE_BITS-1:0] model_scores(
    input logic [HIDDEN_CNT-1:0] hid
);
    logic [CLASS_CNT-1:0][SCORE_BITS-1:0] sc;
    int                                   cnt;
    for (int c = 0; c < CLASS_CNT; c++) begin
        cnt = 0;
        for (int h = 0; h < HIDDEN_CNT; h++) begin
            if (hid[h] == CLS_WEIGHTS[c][h]) begin
                cnt++;
            end
        end
        sc[c] = SCORE_BITS'(cnt);
    end
    return sc;
endfunction

function automatic int model_predict(input logic [FEAT_CNT*FEAT_BITS-1:0] feats);
    logic [CLASS_CNT-1:0][SCORE_BITS-1:0] sc;
    int                                   best;
    sc   = model_scores(model_hidden(feats));
    best = 0;
    for (int c = 1; c < CLASS_CNT; c++) begin
        if (sc[c] > sc[best]) begin
            best = c;       // ties keep the lower index
        end
    end
    return best;
endfunction

`endif

// File: testbench/bnn_classifier_tb.sv
`timescale 1ns/1ps

module bnn_classifier_tb
    import bnn_pkg::*;
();

    `include "bnn_model.svh"

    // tests need about 700 cycles, wide margin on top
    localparam int TIMEOUT_CYCLES = 2000;

    logic                          clk;
    logic                          arst_n;
    logic                          in_valid;
    logic [FEAT_CNT*FEAT_BITS-1:0] features;
    logic                          out_valid;
    logic [CLASS_BITS-1:0]         prediction;

    int          cycle = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          pulse_cnt = 0;
    int          first_out = -1;
    int          last_out = -1;
    int          last_pred = 0;
    int          expected_q [$];
    logic [31:0] lfsr_state;

    bnn_classifier bnn_classifier_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .features   (features),
        .out_valid  (out_valid),
        .prediction (prediction)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // clock, reset, watchdog
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    initial begin
        while (cycle < TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, the tests did not finish", cycle);
        $display("Testbench failed");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r          = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [FEAT_CNT*FEAT_BITS-1:0] rand_features();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = rand_bits(32);
        lo = rand_bits(32);
        return {hi, lo};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    task automatic drive_sample(input logic [FEAT_CNT*FEAT_BITS-1:0] f);
        @(posedge clk);
        in_valid <= 1'b1;
        features <= f;
        expected_q.push_back(model_predict(f));
    endtask

    task automatic drive_idle();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    // wait until every expected prediction has come out
    task automatic drain();
        while (expected_q.size() != 0) @(negedge clk);
        repeat (3) @(negedge clk);
    endtask

    task automatic finish_test(input string name, input int err_start);
        tests++;
        if (errors == err_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err_start);
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (arst_n === 1'b1 && out_valid === 1'b1) begin
            if (first_out < 0) begin
                first_out = cycle;
            end
            last_out  = cycle;
            last_pred = int'(prediction);
            pulse_cnt++;
            if (expected_q.size() == 0) begin
                check_true(1'b0, "out_valid went high with no sample in flight");
            end else begin
                check_value("prediction", 32'(prediction), expected_q.pop_front());
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic test_reset_state();
        int err_start;
        err_start = errors;
        @(posedge clk);
        while (arst_n !== 1'b1) begin
            @(negedge clk);
            check_value("out_valid", 32'(out_valid), 32'h0);
            check_value("prediction", 32'(prediction), 32'h0);
        end
        repeat (3) begin
            @(negedge clk);
            check_value("out_valid", 32'(out_valid), 32'h0);
            check_value("prediction", 32'(prediction), 32'h0);
        end
        finish_test("reset state", err_start);
    endtask

    task automatic test_latency();
        int err_start;
        int edges;
        err_start = errors;
        pulse_cnt = 0;
        drive_sample(rand_features());
        @(posedge clk);
        in_valid <= 1'b0;
        edges = 1;
        @(negedge clk);
        while (out_valid !== 1'b1 && edges < 8) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end
        check_value("latency_edges", 32'(edges), 32'd4);
        repeat (6) @(negedge clk);
        check_value("out_valid_pulses", 32'(pulse_cnt), 32'd1);
        finish_test("fixed latency", err_start);
    endtask

    task automatic test_edge_patterns();
        int err_start;
        err_start = errors;
        drive_sample('0);
        drive_sample('1);   // every feature at 15
        for (int i = 0; i < FEAT_CNT; i++) begin
            drive_sample((FEAT_CNT*FEAT_BITS)'(4'hf) << (i * FEAT_BITS));
        end
        drive_idle();
        drain();
        finish_test("edge patterns", err_start);
    endtask

    task automatic test_back_to_back();
        int err_start;
        err_start = errors;
        pulse_cnt = 0;
        first_out = -1;
        for (int i = 0; i < 300; i++) begin
            drive_sample(rand_features());
        end
        drive_idle();
        drain();
        check_value("out_valid_pulses", 32'(pulse_cnt), 32'd300);
        check_value("out_valid_span", 32'(last_out - first_out), 32'd299);
        finish_test("back-to-back stream", err_start);
    endtask

    task automatic test_gapped();
        int err_start;
        int sent;
        err_start = errors;
        pulse_cnt = 0;
        sent      = 0;
        while (sent < 200) begin
            if (rand_bits(1) == 32'h1) begin
                drive_sample(rand_features());
                sent++;
            end else begin
                drive_idle();
            end
        end
        drive_idle();
        drain();
        check_value("out_valid_pulses", 32'(pulse_cnt), 32'd200);
        finish_test("gapped stream", err_start);
    endtask

    // two passes, find the top score then its first position
    function automatic int first_max_index(
        input logic [CLASS_CNT-1:0][SCORE_BITS-1:0] sc, output int top_cnt
    );
        int top;
        int idx;
        top     = 0;
        idx     = -1;
        top_cnt = 0;
        for (int c = 0; c < CLASS_CNT; c++) begin
            if (int'(sc[c]) > top) begin
                top = int'(sc[c]);
            end
        end
        for (int c = CLASS_CNT - 1; c >= 0; c--) begin
            if (int'(sc[c]) == top) begin
                idx = c;
                top_cnt++;
            end
        end
        return idx;
    endfunction

    task automatic test_tie_rule();
        int                            err_start;
        int                            tie_idx;
        int                            top_cnt;
        logic [FEAT_CNT*FEAT_BITS-1:0] f;
        err_start = errors;
        top_cnt   = 0;
        tie_idx   = -1;
        for (int i = 0; i < 500 && top_cnt < 2; i++) begin
            f       = rand_features();
            tie_idx = first_max_index(model_scores(model_hidden(f)), top_cnt);
        end
        if (top_cnt < 2) begin
            check_true(1'b0, "no sample with a tied top score found in 500 tries");
        end else begin
            drive_sample(f);
            drive_idle();
            drain();
            check_value("tie_prediction", 32'(last_pred), 32'(tie_idx));
        end
        finish_test("tie rule", err_start);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        in_valid   = 1'b0;
        features   = '0;
        lfsr_state = 32'hea4e_334e;
        test_reset_state();
        test_latency();
        test_edge_patterns();
        test_back_to_back();
        test_gapped();
        test_tie_rule();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: verilog/argmax.sv
`timescale 1ns/1ps

module argmax
    import bnn_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  score_vec_t            scores,
    output logic                  out_valid,
    output logic [CLASS_BITS-1:0] prediction
);

    logic [CLASS_BITS-1:0] best_idx;
    logic [SCORE_BITS-1:0] best_val;

    // linear scan, only a strictly larger score replaces the leader
    always_comb begin
        best_idx = '0;
        best_val = scores.score[0];
        for (int c = 1; c < CLASS_CNT; c++) begin
            if (scores.score[c] > best_val) begin
                best_idx = CLASS_BITS'(c);
                best_val = scores.score[c];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid  <= 1'b0;
            prediction <= '0;
        end else begin
            out_valid <= scores.valid;
            if (scores.valid) begin
                prediction <= best_idx;     // hold last result between samples
            end
        end
    end

    a_pred_range : assert property (
        @(posedge clk) disable iff (!arst_n)
        out_valid |-> (prediction < CLASS_BITS'(CLASS_CNT))
    ) else $error("prediction %0d out of range", prediction);

endmodule

// File: verilog/bnn_classifier.sv
`timescale 1ns/1ps

module bnn_classifier
    import bnn_pkg::*;
(
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          in_valid,
    input  logic [FEAT_CNT*FEAT_BITS-1:0] features,
    output logic                          out_valid,
    output logic [CLASS_BITS-1:0]         prediction
);

    sample_t      sample_q;
    hidden_half_t half_lo;
    hidden_half_t half_hi;
    score_vec_t   scores;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // input register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sample_q <= '0;
        end else begin
            sample_q.valid <= in_valid;
            sample_q.feat  <= features;     // feature 0 in the low nibble
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pipeline stages
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    hidden_bank #(
        .BANK (0)
    ) bank_0 (
        .clk    (clk),
        .arst_n (arst_n),
        .sample (sample_q),
        .half   (half_lo)
    );

    hidden_bank #(
        .BANK (1)
    ) bank_1 (
        .clk    (clk),
        .arst_n (arst_n),
        .sample (sample_q),
        .half   (half_hi)
    );

    class_scorer class_scorer_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .half_lo (half_lo),
        .half_hi (half_hi),
        .scores  (scores)
    );

    argmax argmax_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .scores     (scores),
        .out_valid  (out_valid),
        .prediction (prediction)
    );

endmodule
